// ==== camera_pipeline_top.f ====
+incdir+source
source/camera_pkg.sv
source/ccd_capture.sv
source/bayer_demosaic.sv
source/frame_count_display.sv
source/camera_pipeline_top.sv
verification/clock_gen.sv
verification/camera_tb.sv

// ==== source/bayer_demosaic.sv ====
`timescale 1ns/1ns
`include "camera_macros.svh"

module bayer_demosaic (
  input  logic                      CLOCK_50,
  input  logic                      reset,
  input  camera_pkg::ccd_pixel_t    pixel,
  output camera_pkg::pixel_words_t  pixel_out,
  output logic                      pixel_valid
);
  import camera_pkg::*;

  localparam int ADDR_W = $clog2(`CCD_LINE_MAX);

  // Previous row, one sample per column
  logic [`CCD_PIXEL_W-1:0] line_buf [`CCD_LINE_MAX];

  logic [ADDR_W-1:0]       addr;
  logic                    in_range;   // Column fits the line buffer
  logic [`CCD_PIXEL_W-1:0] c;          // Current sample
  logic [`CCD_PIXEL_W-1:0] u;          // Above
  logic [`CCD_PIXEL_W-1:0] l_q;        // Left
  logic [`CCD_PIXEL_W-1:0] ul_q;       // Above-left
  logic                    emit;
  bayer_phase_e            phase;
  logic [`CCD_PIXEL_W:0]   sum_diag;   // c + ul, one spare bit
  logic [`CCD_PIXEL_W:0]   sum_cross;  // l + u
  rgb_t                    rgb;

  assign c        = pixel.data;
  assign in_range = pixel.x < `CCD_LINE_MAX;
  assign addr     = pixel.x[ADDR_W-1:0];
  assign u        = line_buf[addr];    // Read before this row overwrites

  // Full 2x2 window only from second row and column on
  assign emit = pixel.dval && in_range && (pixel.x != '0) && (pixel.y != '0);

  // ========================================
  // Window storage
  // ========================================
  always_ff @(posedge CLOCK_50)
  begin
    if (pixel.dval && in_range)
      line_buf[addr] <= c;
  end

  // Slide window one column right
  always_ff @(posedge CLOCK_50)
  begin
    if (pixel.dval)
    begin
      l_q  <= c;
      ul_q <= u;   // Today's above is tomorrow's above-left
    end
  end

  // ========================================
  // Colour selection
  // ========================================
  assign phase     = bayer_phase_e'({pixel.y[0], pixel.x[0]});
  assign sum_diag  = {1'b0, c} + {1'b0, ul_q};
  assign sum_cross = {1'b0, l_q} + {1'b0, u};

  always_comb
  begin
    case (phase)
      GR_EVEN_EVEN:   // Green on a G R row
      begin
        rgb.red   = l_q;
        rgb.blue  = u;
        rgb.green = sum_diag[`CCD_PIXEL_W:1];
      end
      R_EVEN_ODD:
      begin
        rgb.red   = c;
        rgb.blue  = ul_q;
        rgb.green = sum_cross[`CCD_PIXEL_W:1];
      end
      B_ODD_EVEN:
      begin
        rgb.red   = ul_q;
        rgb.blue  = c;
        rgb.green = sum_cross[`CCD_PIXEL_W:1];
      end
      default:        // Green on a B G row
      begin
        rgb.red   = u;
        rgb.blue  = l_q;
        rgb.green = sum_diag[`CCD_PIXEL_W:1];
      end
    endcase
  end

  // ========================================
  // Output words
  // ========================================
  always_ff @(posedge CLOCK_50)
  begin
    if (reset)
      pixel_valid <= 1'b0;
    else
      pixel_valid <= emit;
  end

  // Top 10 bits of red and blue, green split 5 and 5
  always_ff @(posedge CLOCK_50)
  begin
    if (emit)
    begin
      pixel_out.word_a <= {1'b0, rgb.green[11:7], rgb.blue[11:2]};
      pixel_out.word_b <= {1'b0, rgb.green[6:2], rgb.red[11:2]};
    end
  end

endmodule

// ==== source/camera_macros.svh ====
`ifndef CAMERA_MACROS_SVH
`define CAMERA_MACROS_SVH

// ========================================
// Sensor sample geometry
// ========================================

// Raw sensor sample width, also each colour channel
`define CCD_PIXEL_W 12

// Line buffer depth, one full sensor row
`define CCD_LINE_MAX 640

// X and Y coordinate counter width
`define CCD_COORD_W 16

// ========================================
// Frame statistics and display
// ========================================

`define FRAME_CNT_W 32   // Free running frame counter

// Seven-segment digits shown, one nibble each
`define HEX_DIGITS 6

`endif

// ==== source/camera_pipeline_top.sv ====
`timescale 1ns/1ns
`include "camera_macros.svh"

module camera_pipeline_top (
  input  logic                      CLOCK_50,
  input  logic                      reset,
  input  camera_pkg::ccd_raw_t      ccd_in,         // Sensor data, fval, lval
  input  logic                      capture_start,  // One-cycle pulse
  input  logic                      capture_end,    // One-cycle pulse
  output camera_pkg::pixel_words_t  pixel_out,
  output logic                      pixel_valid,
  output logic [`FRAME_CNT_W-1:0]   frame_count,
  output camera_pkg::hex_display_t  hex
);
  import camera_pkg::*;

  ccd_pixel_t cap_pixel;   // Capture to demosaic

  // ========================================
  // Sensor capture, 2 cycles
  // ========================================
  ccd_capture u_capture (
    .CLOCK_50      (CLOCK_50),
    .reset         (reset),
    .ccd_in        (ccd_in),
    .capture_start (capture_start),
    .capture_end   (capture_end),
    .pixel         (cap_pixel),
    .frame_count   (frame_count)
  );

  // ========================================
  // Bayer to RGB, 1 cycle
  // ========================================
  bayer_demosaic u_demosaic (
    .CLOCK_50    (CLOCK_50),
    .reset       (reset),
    .pixel       (cap_pixel),
    .pixel_out   (pixel_out),
    .pixel_valid (pixel_valid)
  );

  // Frame count on HEX5..HEX0
  frame_count_display u_display (
    .CLOCK_50    (CLOCK_50),
    .reset       (reset),
    .frame_count (frame_count),
    .hex         (hex)
  );

endmodule

// ==== source/camera_pkg.sv ====
`include "camera_macros.svh"

package camera_pkg;

  // ========================================
  // Sample and pixel records
  // ========================================

  // Sensor sample as it leaves the pins
  typedef struct packed {
    logic [`CCD_PIXEL_W-1:0] data;   // Raw Bayer sample
    logic                    fval;   // Frame valid level
    logic                    lval;   // Line valid level
  } ccd_raw_t;

  // Captured pixel with its position
  typedef struct packed {
    logic [`CCD_PIXEL_W-1:0] data;
    logic [`CCD_COORD_W-1:0] x;      // Column within the line
    logic [`CCD_COORD_W-1:0] y;      // Row within the frame
    logic                    dval;   // Pixel belongs to a captured frame
  } ccd_pixel_t;

  typedef struct packed {
    logic [`CCD_PIXEL_W-1:0] red;
    logic [`CCD_PIXEL_W-1:0] green;
    logic [`CCD_PIXEL_W-1:0] blue;
  } rgb_t;

  // Two 16-bit frame buffer words per pixel
  typedef struct packed {
    logic [15:0] word_a;   // 0, green high bits, blue
    logic [15:0] word_b;   // 0, green low bits, red
  } pixel_words_t;

  // ========================================
  // Control encodings
  // ========================================

  // Encoded as {y[0], x[0]}
  typedef enum logic [1:0] {
    GR_EVEN_EVEN = 2'b00,
    R_EVEN_ODD   = 2'b01,
    B_ODD_EVEN   = 2'b10,
    G_ODD_ODD    = 2'b11
  } bayer_phase_e;

  typedef enum logic [1:0] {
    CAP_IDLE,       // Waiting for start pulse
    CAP_ARMED,      // Waiting for next frame start
    CAP_RUN,        // Capturing frames
    CAP_STOPPING    // Finishing current frame
  } capture_state_e;

  // Active-low segments, gfedcba per digit
  typedef struct packed {
    logic [6:0] hex5;
    logic [6:0] hex4;
    logic [6:0] hex3;
    logic [6:0] hex2;
    logic [6:0] hex1;
    logic [6:0] hex0;   // Least significant digit
  } hex_display_t;

endpackage

// ==== source/ccd_capture.sv ====
`timescale 1ns/1ns
`include "camera_macros.svh"

module ccd_capture (
  input  logic                      CLOCK_50,
  input  logic                      reset,
  input  camera_pkg::ccd_raw_t      ccd_in,
  input  logic                      capture_start,
  input  logic                      capture_end,
  output camera_pkg::ccd_pixel_t    pixel,
  output logic [`FRAME_CNT_W-1:0]   frame_count
);
  import camera_pkg::*;

  ccd_raw_t                raw_q;       // Registered sensor sample
  logic                    fval_prev;   // fval one sample back
  logic                    lval_prev;   // lval one sample back
  logic                    start_q;
  logic                    end_q;
  capture_state_e          state;
  capture_state_e          state_nxt;
  logic                    fval_rise;
  logic                    fval_fall;
  logic                    lval_fall;
  logic                    frame_start;  // New frame counted
  logic                    capturing;
  logic [`CCD_PIXEL_W-1:0] data_q;
  logic [`CCD_COORD_W-1:0] x_q;
  logic [`CCD_COORD_W-1:0] y_q;
  logic                    dval_q;

  // ========================================
  // Input register
  // ========================================
  always_ff @(posedge CLOCK_50)
  begin
    if (reset)
    begin
      raw_q     <= '0;
      fval_prev <= 1'b0;
      lval_prev <= 1'b0;
      start_q   <= 1'b0;
      end_q     <= 1'b0;
    end
    else
    begin
      raw_q     <= ccd_in;
      fval_prev <= raw_q.fval;   // Edge history
      lval_prev <= raw_q.lval;
      start_q   <= capture_start;
      end_q     <= capture_end;
    end
  end

  assign fval_rise = raw_q.fval & ~fval_prev;
  assign fval_fall = ~raw_q.fval & fval_prev;
  assign lval_fall = ~raw_q.lval & lval_prev;

  // ========================================
  // Capture controller
  // ========================================
  always_comb
  begin
    state_nxt   = state;
    frame_start = 1'b0;
    case (state)
      CAP_IDLE:
        if (start_q)
          state_nxt = CAP_ARMED;
      CAP_ARMED:
        if (fval_rise)
        begin
          frame_start = 1'b1;
          state_nxt   = CAP_RUN;
        end
      CAP_RUN:
      begin
        frame_start = fval_rise;            // Back-to-back frames
        if (end_q)
          state_nxt = CAP_STOPPING;   // Let this frame run out
      end
      CAP_STOPPING:
        if (fval_fall)
          state_nxt = CAP_IDLE;
      default: state_nxt = CAP_IDLE;
    endcase
  end

  // Sample counts when frame is live after this edge
  assign capturing = (state_nxt == CAP_RUN) || (state_nxt == CAP_STOPPING);

  always_ff @(posedge CLOCK_50)
  begin
    if (reset)
    begin
      state       <= CAP_IDLE;
      frame_count <= '0;
      x_q         <= '0;
      y_q         <= '0;
      dval_q      <= 1'b0;
    end
    else
    begin
      state  <= state_nxt;
      dval_q <= raw_q.fval & raw_q.lval & capturing;
      if (frame_start)
        frame_count <= frame_count + 1'b1;
      if (fval_rise || !raw_q.lval || !lval_prev)
        x_q <= '0;                   // First column or blanking
      else
        x_q <= x_q + 1'b1;
      if (fval_rise)
        y_q <= '0;
      else if (lval_fall && raw_q.fval)
        y_q <= y_q + 1'b1;           // Line ended inside frame
    end
  end

  always_ff @(posedge CLOCK_50)
    data_q <= raw_q.data;

  assign pixel = '{data: data_q, x: x_q, y: y_q, dval: dval_q};

endmodule

// ==== source/frame_count_display.sv ====
`timescale 1ns/1ns
`include "camera_macros.svh"

module frame_count_display (
  input  logic                      CLOCK_50,
  input  logic                      reset,
  input  logic [`FRAME_CNT_W-1:0]   frame_count,
  output camera_pkg::hex_display_t  hex
);
  import camera_pkg::*;

  logic [`HEX_DIGITS-1:0][6:0] seg_next;   // Digit 0 in low bits

  // Active-low gfedcba, common anode
  function automatic logic [6:0] seg7(input logic [3:0] nib);
    logic [6:0] seg;
    case (nib)
      4'h0: seg = 7'h40;
      4'h1: seg = 7'h79;
      4'h2: seg = 7'h24;
      4'h3: seg = 7'h30;
      4'h4: seg = 7'h19;
      4'h5: seg = 7'h12;
      4'h6: seg = 7'h02;
      4'h7: seg = 7'h78;
      4'h8: seg = 7'h00;
      4'h9: seg = 7'h10;
      4'hA: seg = 7'h08;
      4'hB: seg = 7'h03;
      4'hC: seg = 7'h46;
      4'hD: seg = 7'h21;
      4'hE: seg = 7'h06;
      default: seg = 7'h0E;   // F
    endcase
    return seg;
  endfunction

  // ========================================
  // Nibble decode
  // ========================================
  always_comb
  begin
    for (int i = 0; i < `HEX_DIGITS; i++)
      seg_next[i] = seg7(frame_count[4*i +: 4]);   // Low 24 bits only
  end

  always_ff @(posedge CLOCK_50)
  begin
    if (reset)
      hex <= hex_display_t'({`HEX_DIGITS{7'h40}});   // "000000"
    else
      hex <= hex_display_t'(seg_next);
  end

endmodule

// ==== verification/camera_tb.sv ====
`timescale 1ns/1ns
`include "camera_macros.svh"

module camera_tb;
  import camera_pkg::*;

  localparam int clk_period   = 4;
  localparam int line_len     = 16;
  localparam int frame_lines  = 6;
  localparam int line_gap     = 4;    // lval low between lines
  localparam int frame_gap    = 12;   // fval low plus lead-in
  localparam int fval_lead    = 2;
  localparam int total_frames = 10;

  typedef enum {FILL_RANDOM, FILL_ONES, FILL_ZEROS, FILL_ALT} fill_e;

  typedef struct packed {
    pixel_words_t words;
    logic [31:0]  due;   // Edge count when the word is out
  } expect_t;

  logic                    CLOCK_50;
  logic                    reset;
  ccd_raw_t                ccd_in;
  logic                    capture_start;
  logic                    capture_end;
  pixel_words_t            pixel_out;
  logic                    pixel_valid;
  logic [`FRAME_CNT_W-1:0] frame_count;
  hex_display_t            hex;

  logic [`CCD_PIXEL_W-1:0] frame_mem [frame_lines][line_len];   // Frame being sent
  expect_t                 exp_q [$];
  expect_t                 head;
  logic [31:0]             cycle = 0;
  logic [`FRAME_CNT_W-1:0] model_count = 0;   // Count the DUT should show now
  logic [31:0]             count_edge = 0;    // Edge where the next count lands
  logic [`FRAME_CNT_W-1:0] expected_count = 0;
  string                   cur_test = "reset";

  clock_gen #(.period_ns(clk_period), .reset_cycles(5)) clk0 (
    .CLOCK_50 (CLOCK_50),
    .reset    (reset)
  );

  camera_pipeline_top dut0 (
    .CLOCK_50      (CLOCK_50),
    .reset         (reset),
    .ccd_in        (ccd_in),
    .capture_start (capture_start),
    .capture_end   (capture_end),
    .pixel_out     (pixel_out),
    .pixel_valid   (pixel_valid),
    .frame_count   (frame_count),
    .hex           (hex)
  );

  // ========================================
  // Reference model
  // ========================================
  function automatic logic [6:0] seg_pattern(input logic [3:0] nib);
    case (nib)
      4'h0: return 7'h40;
      4'h1: return 7'h79;
      4'h2: return 7'h24;
      4'h3: return 7'h30;
      4'h4: return 7'h19;
      4'h5: return 7'h12;
      4'h6: return 7'h02;
      4'h7: return 7'h78;
      4'h8: return 7'h00;
      4'h9: return 7'h10;
      4'hA: return 7'h08;
      4'hB: return 7'h03;
      4'hC: return 7'h46;
      4'hD: return 7'h21;
      4'hE: return 7'h06;
      default: return 7'h0E;
    endcase
  endfunction

  function automatic hex_display_t hex_ref(input logic [`FRAME_CNT_W-1:0] count);
    hex_display_t h;
    h.hex0 = seg_pattern(count[3:0]);     // Least significant digit
    h.hex1 = seg_pattern(count[7:4]);
    h.hex2 = seg_pattern(count[11:8]);
    h.hex3 = seg_pattern(count[15:12]);
    h.hex4 = seg_pattern(count[19:16]);
    h.hex5 = seg_pattern(count[23:20]);
    return h;
  endfunction

  // G R on even rows, B G on odd rows
  function automatic pixel_words_t ref_pixel(input int x, input int y);
    logic [11:0]  c;
    logic [11:0]  l;
    logic [11:0]  u;
    logic [11:0]  ul;
    logic [12:0]  sum_cul;
    logic [12:0]  sum_lu;
    logic [11:0]  r;
    logic [11:0]  g;
    logic [11:0]  b;
    pixel_words_t w;
    c       = frame_mem[y][x];
    l       = frame_mem[y][x-1];
    u       = frame_mem[y-1][x];
    ul      = frame_mem[y-1][x-1];
    sum_cul = c + ul;   // 13-bit sums, halved by truncation
    sum_lu  = l + u;
    case ({y[0], x[0]})
      2'b00:
      begin
        r = l;
        b = u;
        g = sum_cul[12:1];
      end
      2'b01:
      begin
        r = c;
        b = ul;
        g = sum_lu[12:1];
      end
      2'b10:
      begin
        r = ul;
        b = c;
        g = sum_lu[12:1];
      end
      default:
      begin
        r = u;
        b = l;
        g = sum_cul[12:1];
      end
    endcase
    w.word_a = {1'b0, g[11:7], b[11:2]};
    w.word_b = {1'b0, g[6:2], r[11:2]};
    return w;
  endfunction

  // ========================================
  // Checks
  // ========================================
  task automatic fail_stop();
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_pixel(input string name, input pixel_words_t exp,
                             input pixel_words_t act);
    if (act !== exp)
    begin
      $display("[FAIL] %s pixel expected %h actual %h", name, exp, act);
      fail_stop();
    end
  endtask

  task automatic check_count(input string name, input logic [`FRAME_CNT_W-1:0] exp,
                             input logic [`FRAME_CNT_W-1:0] act);
    if (act !== exp)
    begin
      $display("[FAIL] %s frame_count expected %h actual %h", name, exp, act);
      fail_stop();
    end
  endtask

  task automatic check_hex(input string name, input hex_display_t exp,
                           input hex_display_t act);
    if (act !== exp)
    begin
      $display("[FAIL] %s hex expected %h actual %h", name, exp, act);
      fail_stop();
    end
  endtask

  task automatic check_totals(input string name);
    @(negedge CLOCK_50);
    check_count(name, expected_count, frame_count);
    check_hex(name, hex_ref(expected_count), hex);
  endtask

  always @(posedge CLOCK_50)
    cycle <= cycle + 1;

  // Pops one entry per output word, in order
  always @(negedge CLOCK_50)
  begin
    if (!reset && pixel_valid)
    begin
      if (exp_q.size() == 0)
      begin
        $display("pixel_valid high in test %s with no pixel expected", cur_test);
        fail_stop();
      end
      else
      begin
        head = exp_q.pop_front();
        if (cycle != head.due)
        begin
          $display("Pixel in test %s came out at cycle %0d, due at %0d",
                   cur_test, cycle, head.due);
          fail_stop();
        end
        else
          check_pixel(cur_test, head.words, pixel_out);
      end
    end
  end

  // Count lands two edges after the lead sample, hex one edge later
  always @(negedge CLOCK_50)
  begin
    if (reset === 1'b0)
    begin
      check_hex(cur_test, hex_ref(model_count), hex);   // Still the previous count
      if (cycle == count_edge)
        model_count = expected_count;
      check_count(cur_test, model_count, frame_count);
    end
  end

  // Whole run with a factor 2 margin
  initial
  begin
    #(total_frames * (frame_lines * (line_len + line_gap) + frame_gap) * clk_period * 2);
    $display("Timeout in test %s, the run did not finish in time", cur_test);
    fail_stop();
  end

  // ========================================
  // Stimulus
  // ========================================
  task automatic fill_frame(input fill_e mode);
    logic [31:0] rnd;
    for (int y = 0; y < frame_lines; y++)
    begin
      for (int x = 0; x < line_len; x++)
      begin
        rnd = $urandom();
        case (mode)
          FILL_RANDOM: frame_mem[y][x] = rnd[11:0];
          FILL_ONES:   frame_mem[y][x] = 12'hFFF;
          FILL_ZEROS:  frame_mem[y][x] = 12'h000;
          default:     frame_mem[y][x] = ((x + y) % 2) ? 12'hFFF : 12'h000;   // Checkerboard
        endcase
      end
    end
  endtask

  task automatic pulse_start();
    @(posedge CLOCK_50);
    capture_start <= 1'b1;
    @(posedge CLOCK_50);
    capture_start <= 1'b0;
  endtask

  // One frame of frame_mem, optional capture_end on line 2
  task automatic send_frame(input logic captured, input logic stop_mid);
    expect_t entry;
    @(posedge CLOCK_50);
    ccd_in <= '{data: '0, fval: 1'b1, lval: 1'b0};
    repeat (fval_lead - 1) @(posedge CLOCK_50);
    if (captured)
    begin
      expected_count = expected_count + 1;
      count_edge     = cycle + 2;   // Input and edge registers
    end
    for (int y = 0; y < frame_lines; y++)
    begin
      for (int x = 0; x < line_len; x++)
      begin
        @(posedge CLOCK_50);
        ccd_in      <= '{data: frame_mem[y][x], fval: 1'b1, lval: 1'b1};
        capture_end <= stop_mid && (y == 2) && (x == 0);
        if (captured && x >= 1 && y >= 1)
        begin
          entry.words = ref_pixel(x, y);
          entry.due   = cycle + 4;   // Counter lags one edge
          exp_q.push_back(entry);
        end
      end
      repeat (line_gap)
      begin
        @(posedge CLOCK_50);
        ccd_in <= '{data: '0, fval: 1'b1, lval: 1'b0};
      end
    end
    @(posedge CLOCK_50);
    ccd_in <= '0;
    repeat (frame_gap - fval_lead - 1) @(posedge CLOCK_50);
  endtask

  initial
  begin
    void'($urandom(32'h21ecac64));
    ccd_in        = '0;
    capture_start = 1'b0;
    capture_end   = 1'b0;
    while (reset !== 1'b0) @(posedge CLOCK_50);
    check_totals("reset");
    cur_test = "idle";   // Frames stream, controller never armed
    repeat (2)
    begin
      fill_frame(FILL_RANDOM);
      send_frame(1'b0, 1'b0);
    end
    check_totals("idle");
    cur_test = "demosaic";
    pulse_start();
    repeat (2)
    begin
      fill_frame(FILL_RANDOM);
      send_frame(1'b1, 1'b0);
      check_totals("demosaic");
    end
    cur_test = "packing";
    fill_frame(FILL_ONES);
    send_frame(1'b1, 1'b0);
    fill_frame(FILL_ZEROS);
    send_frame(1'b1, 1'b0);
    fill_frame(FILL_ALT);
    send_frame(1'b1, 1'b0);
    check_totals("packing");
    cur_test = "stop_restart";
    fill_frame(FILL_RANDOM);
    send_frame(1'b1, 1'b1);   // Ended frame still completes
    check_totals("stop_restart");
    fill_frame(FILL_RANDOM);
    send_frame(1'b0, 1'b0);
    check_totals("stop_restart");
    pulse_start();
    fill_frame(FILL_RANDOM);
    send_frame(1'b1, 1'b0);
    check_totals("stop_restart");
    repeat (8) @(posedge CLOCK_50);
    @(negedge CLOCK_50);
    if (exp_q.size() != 0)
    begin
      $display("%0d expected pixels never came out", exp_q.size());
      fail_stop();
    end
    else
    begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

// ==== verification/clock_gen.sv ====
`timescale 1ns/1ns

module clock_gen #(
  parameter int period_ns    = 4,
  parameter int reset_cycles = 5
) (
  output logic CLOCK_50,
  output logic reset
);

  initial
  begin
    CLOCK_50 = 1'b0;
    forever #(period_ns / 2) CLOCK_50 = ~CLOCK_50;
  end

  // Released on an edge like any other input
  initial
  begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge CLOCK_50);
    reset <= 1'b0;
  end

endmodule
